//--- files.f
+incdir+include
src/rv_pkg.sv
src/fetch_unit.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_core_top.sv
verif/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_rv_core

verilator --binary --assert --top-module "$TOP" -f files.f -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: instruction word, retire pc, retire rd, retire wdata
// rows in retirement order, squashed slots are left to the fill pattern
localparam int PROG_LEN = 24;

localparam logic [127:0] PROG [PROG_LEN] = '{
    {32'h0050_0093, 32'h0000_0000, 32'd1,  32'h0000_0005},  // addi x1, x0, 5
    {32'hffd0_8113, 32'h0000_0004, 32'd2,  32'h0000_0002},  // addi x2, x1, -3
    {32'h0020_81b3, 32'h0000_0008, 32'd3,  32'h0000_0007},  // add  x3, x1, x2
    {32'h4011_8233, 32'h0000_000c, 32'd4,  32'h0000_0002},  // sub  x4, x3, x1
    {32'h0ff2_4293, 32'h0000_0010, 32'd5,  32'h0000_00fd},  // xori x5, x4, 0xff
    {32'h7002_e313, 32'h0000_0014, 32'd6,  32'h0000_07fd},  // ori  x6, x5, 0x700
    {32'hff03_7393, 32'h0000_0018, 32'd7,  32'h0000_07f0},  // andi x7, x6, -16
    {32'h0053_f433, 32'h0000_001c, 32'd8,  32'h0000_00f0},  // and  x8, x7, x5
    {32'h0024_64b3, 32'h0000_0020, 32'd9,  32'h0000_00f2},  // or   x9, x8, x2
    {32'h0064_c533, 32'h0000_0024, 32'd10, 32'h0000_070f},  // xor  x10, x9, x6
    {32'habcd_e5b7, 32'h0000_0028, 32'd11, 32'habcd_e000},  // lui  x11, 0xabcde
    {32'hfff5_8593, 32'h0000_002c, 32'd11, 32'habcd_dfff},  // addi x11, x11, -1
    {32'h07b0_0013, 32'h0000_0030, 32'd0,  32'h0000_0000},  // addi x0, x0, 123
    {32'h00a0_0633, 32'h0000_0034, 32'd12, 32'h0000_070f},  // add  x12, x0, x10
    {32'h0010_8093, 32'h0000_0038, 32'd1,  32'h0000_0006},  // addi x1, x1, 1
    {32'h0020_8463, 32'h0000_003c, 32'd0,  32'h0000_0000},  // beq  x1, x2, +8 not taken
    {32'h0020_9663, 32'h0000_0040, 32'd0,  32'h0000_0000},  // bne  x1, x2, +12 taken
    {32'hffa0_8693, 32'h0000_004c, 32'd13, 32'h0000_0000},  // addi x13, x1, -6
    {32'h0006_8863, 32'h0000_0050, 32'd0,  32'h0000_0000},  // beq  x13, x0, +16 taken
    {32'h00c0_076f, 32'h0000_0060, 32'd14, 32'h0000_0064},  // jal  x14, +12
    {32'h00c7_07b3, 32'h0000_006c, 32'd15, 32'h0000_0773},  // add  x15, x14, x12
    {32'hfef7_98e3, 32'h0000_0070, 32'd0,  32'h0000_0000},  // bne  x15, x15, -16
    {32'h40f0_0833, 32'h0000_0074, 32'd16, 32'hffff_f88d},  // sub  x16, x0, x15
    {32'h0000_006f, 32'h0000_0078, 32'd0,  32'h0000_0000}   // jal  x0, 0 (self loop)
};

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int XLEN         = 32;
    localparam int IMEM_WORDS   = 64;
    localparam int AW           = $clog2(IMEM_WORDS);
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int CHAIN_LEN    = 16;
    localparam logic [31:0] SEED = 32'h909c_f538;

    `include "tb_program.svh"

    // resets, memory fill, both loads and both runs, plus margin
    localparam int WATCHDOG_CYCLES = 2 * RESET_CYCLES + IMEM_WORDS
                                   + 3 * (PROG_LEN + CHAIN_LEN + 1) + 40;

    logic            clk = 1'b0;
    logic            rst_n_i;
    logic            run_i;
    logic            imem_we_i;
    logic [AW-1:0]   imem_addr_i;
    logic [31:0]     imem_wdata_i;
    logic            retire_valid_o;
    logic [XLEN-1:0] retire_pc_o;
    logic [31:0]     retire_instr_o;
    logic [4:0]      retire_rd_o;
    logic [XLEN-1:0] retire_wdata_o;

    int errors    = 0;
    int checks    = 0;
    int phase     = 1;   // 1 = program table, 2 = addi chain
    int prog_idx  = 0;
    int chain_idx = 0;

    logic [31:0] chain_word [CHAIN_LEN];
    logic [31:0] chain_exp  [CHAIN_LEN];
    logic [31:0] last_x1 = '0;

    rv_core_top #(.XLEN(XLEN), .IMEM_WORDS(IMEM_WORDS)) UUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .run_i          (run_i),
        .imem_we_i      (imem_we_i),
        .imem_addr_i    (imem_addr_i),
        .imem_wdata_i   (imem_wdata_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n_i <= 1'b0;
        run_i   <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    task automatic write_imem(input logic [AW-1:0] addr, input logic [31:0] word);
        @(posedge clk);
        imem_we_i    <= 1'b1;
        imem_addr_i  <= addr;
        imem_wdata_i <= word;
    endtask

    task automatic end_load();
        @(posedge clk);
        imem_we_i <= 1'b0;
    endtask

    task automatic start_run();
        @(negedge clk);
        compare_value("retire_valid_o", 32'd0, 32'(retire_valid_o));   // idle before run
        @(posedge clk);
        run_i <= 1'b1;
    endtask

    // retirement monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n_i && retire_valid_o) begin
            if (phase == 1 && prog_idx < PROG_LEN) begin
                compare_value("retire_pc_o", PROG[prog_idx][95:64], retire_pc_o);
                compare_value("retire_instr_o", PROG[prog_idx][127:96], retire_instr_o);
                compare_value("retire_rd_o", PROG[prog_idx][63:32], 32'(retire_rd_o));
                compare_value("retire_wdata_o", PROG[prog_idx][31:0], retire_wdata_o);
                prog_idx = prog_idx + 1;
            end else if (phase == 2 && chain_idx < CHAIN_LEN) begin
                compare_value("retire_pc_o", 32'(chain_idx * 4), retire_pc_o);
                compare_value("retire_rd_o", 32'd1, 32'(retire_rd_o));
                compare_value("retire_wdata_o", chain_exp[chain_idx], retire_wdata_o);
                chain_idx = chain_idx + 1;
            end
            if (phase == 2 && retire_rd_o == 5'd1) begin
                last_x1 = retire_wdata_o;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the core did not retire all expected instructions in time");
        $display("checks: %0d errors: %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        logic [31:0] lcg_state;
        logic [31:0] run_sum;
        logic [11:0] imm;

        rst_n_i      = 1'b0;
        run_i        = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;

        // addi x1, x1, imm chain and its running sum
        lcg_state = SEED;
        run_sum   = '0;
        for (int n = 0; n < CHAIN_LEN; n++) begin
            lcg_state     = lcg_next(lcg_state);
            imm           = lcg_state[31:20];
            run_sum       = run_sum + {{20{imm[11]}}, imm};
            chain_word[n] = {imm, 5'd1, 3'b000, 5'd1, 7'b0010011};
            chain_exp[n]  = run_sum;
        end

        apply_reset();
        for (int a = 0; a < IMEM_WORDS; a++) begin
            write_imem(AW'(a), {12'(a), 5'd0, 3'b000, 5'd31, 7'b0010011});   // addi x31, x0, a
        end
        for (int n = 0; n < PROG_LEN; n++) begin
            write_imem(AW'(PROG[n][95:64] >> 2), PROG[n][127:96]);
        end
        end_load();
        start_run();
        while (prog_idx < PROG_LEN) @(posedge clk);

        apply_reset();
        phase = 2;
        for (int n = 0; n < CHAIN_LEN; n++) begin
            write_imem(AW'(n), chain_word[n]);
        end
        write_imem(AW'(CHAIN_LEN), 32'h0000_006f);   // jal x0, 0
        end_load();
        start_run();
        while (chain_idx < CHAIN_LEN) @(posedge clk);

        @(negedge clk);
        compare_value("x1 final", chain_exp[CHAIN_LEN-1], last_x1);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter int XLEN       = 32,
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          run_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  logic [31:0]                   imem_wdata_i,
    output logic                          retire_valid_o,
    output logic [XLEN-1:0]               retire_pc_o,
    output logic [31:0]                   retire_instr_o,
    output logic [4:0]                    retire_rd_o,
    output logic [XLEN-1:0]               retire_wdata_o
);

    import rv_pkg::*;

    logic            if_valid;
    logic [XLEN-1:0] if_pc;
    logic [31:0]     if_instr;

    logic            ex_valid;
    logic [XLEN-1:0] ex_pc;
    alu_op_e         ex_op;
    logic [XLEN-1:0] ex_a, ex_b, ex_imm;
    logic [4:0]      ex_rd;
    logic            ex_is_branch, ex_branch_ne, ex_is_jal;
    logic [31:0]     ex_instr;

    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] ex_result;
    logic [4:0]      ex_rd_fwd;
    logic            ex_fwd_valid;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [XLEN-1:0] wb_data;

    fetch_unit #(.XLEN(XLEN), .IMEM_WORDS(IMEM_WORDS)) u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .run_i         (run_i),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_wdata_i  (imem_wdata_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .if_valid_o    (if_valid),
        .if_pc_o       (if_pc),
        .if_instr_o    (if_instr)
    );

    decode_stage #(.XLEN(XLEN)) u_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .if_valid_i     (if_valid),
        .if_pc_i        (if_pc),
        .if_instr_i     (if_instr),
        .flush_i        (redirect),     // squashes ID and EX
        .ex_result_i    (ex_result),
        .ex_rd_fwd_i    (ex_rd_fwd),
        .ex_fwd_valid_i (ex_fwd_valid),
        .wb_valid_i     (wb_valid),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .ex_valid_o     (ex_valid),
        .ex_pc_o        (ex_pc),
        .ex_op_o        (ex_op),
        .ex_a_o         (ex_a),
        .ex_b_o         (ex_b),
        .ex_imm_o       (ex_imm),
        .ex_rd_o        (ex_rd),
        .ex_is_branch_o (ex_is_branch),
        .ex_branch_ne_o (ex_branch_ne),
        .ex_is_jal_o    (ex_is_jal),
        .ex_instr_o     (ex_instr)
    );

    execute_stage #(.XLEN(XLEN)) u_execute (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_pc_i        (ex_pc),
        .ex_op_i        (ex_op),
        .ex_a_i         (ex_a),
        .ex_b_i         (ex_b),
        .ex_imm_i       (ex_imm),
        .ex_rd_i        (ex_rd),
        .ex_is_branch_i (ex_is_branch),
        .ex_branch_ne_i (ex_branch_ne),
        .ex_is_jal_i    (ex_is_jal),
        .ex_instr_i     (ex_instr),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .ex_result_o    (ex_result),
        .ex_rd_fwd_o    (ex_rd_fwd),
        .ex_fwd_valid_o (ex_fwd_valid),
        .wb_valid_o     (wb_valid),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o),
        .retire_rd_o    (retire_rd_o),
        .retire_wdata_o (retire_wdata_o)
    );

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             ex_valid_i,
    input  logic [XLEN-1:0]  ex_pc_i,
    input  rv_pkg::alu_op_e  ex_op_i,
    input  logic [XLEN-1:0]  ex_a_i,
    input  logic [XLEN-1:0]  ex_b_i,
    input  logic [XLEN-1:0]  ex_imm_i,
    input  logic [4:0]       ex_rd_i,
    input  logic             ex_is_branch_i,
    input  logic             ex_branch_ne_i,
    input  logic             ex_is_jal_i,
    input  logic [31:0]      ex_instr_i,
    output logic             redirect_o,
    output logic [XLEN-1:0]  redirect_pc_o,
    output logic [XLEN-1:0]  ex_result_o,
    output logic [4:0]       ex_rd_fwd_o,
    output logic             ex_fwd_valid_o,
    output logic             wb_valid_o,
    output logic [4:0]       wb_rd_o,
    output logic [XLEN-1:0]  wb_data_o,
    output logic             retire_valid_o,
    output logic [XLEN-1:0]  retire_pc_o,
    output logic [31:0]      retire_instr_o,
    output logic [4:0]       retire_rd_o,
    output logic [XLEN-1:0]  retire_wdata_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic            taken;

    always_comb begin
        case (ex_op_i)
            ALU_ADD:    alu_res = ex_a_i + ex_b_i;
            ALU_SUB:    alu_res = ex_a_i - ex_b_i;
            ALU_AND:    alu_res = ex_a_i & ex_b_i;
            ALU_OR:     alu_res = ex_a_i | ex_b_i;
            ALU_XOR:    alu_res = ex_a_i ^ ex_b_i;
            ALU_PASS_B: alu_res = ex_b_i;
            ALU_LINK:   alu_res = ex_pc_i + XLEN'(4);
            default:    alu_res = '0;
        endcase
    end

    assign taken         = ex_is_branch_i && ((ex_a_i == ex_b_i) ^ ex_branch_ne_i);
    assign redirect_o    = ex_valid_i && (ex_is_jal_i || taken);
    assign redirect_pc_o = ex_pc_i + ex_imm_i;   // same adder form for beq/bne/jal

    assign ex_result_o    = alu_res;
    assign ex_rd_fwd_o    = ex_rd_i;
    assign ex_fwd_valid_o = ex_valid_i && (ex_rd_i != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            wb_valid_o     <= 1'b0;
        end else begin
            retire_valid_o <= ex_valid_i;
            wb_valid_o     <= ex_fwd_valid_o;
        end
    end

    // branches and dead writes retire as rd 0 / data 0
    always_ff @(posedge clk) begin
        wb_rd_o        <= ex_rd_i;
        wb_data_o      <= (ex_rd_i == 5'd0) ? '0 : alu_res;
        retire_pc_o    <= ex_pc_i;
        retire_instr_o <= ex_instr_i;
    end

    assign retire_rd_o    = wb_rd_o;
    assign retire_wdata_o = wb_data_o;

    // the flush in decode must leave a bubble behind every redirect
    a_redirect_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> ex_valid_i ##1 !ex_valid_i
    );

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
    parameter int XLEN = 32
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             if_valid_i,
    input  logic [XLEN-1:0]  if_pc_i,
    input  logic [31:0]      if_instr_i,
    input  logic             flush_i,
    input  logic [XLEN-1:0]  ex_result_i,
    input  logic [4:0]       ex_rd_fwd_i,
    input  logic             ex_fwd_valid_i,
    input  logic             wb_valid_i,
    input  logic [4:0]       wb_rd_i,
    input  logic [XLEN-1:0]  wb_data_i,
    output logic             ex_valid_o,
    output logic [XLEN-1:0]  ex_pc_o,
    output rv_pkg::alu_op_e  ex_op_o,
    output logic [XLEN-1:0]  ex_a_o,
    output logic [XLEN-1:0]  ex_b_o,
    output logic [XLEN-1:0]  ex_imm_o,
    output logic [4:0]       ex_rd_o,
    output logic             ex_is_branch_o,
    output logic             ex_branch_ne_o,
    output logic             ex_is_jal_o,
    output logic [31:0]      ex_instr_o
);

    import rv_pkg::*;

    logic            id_valid;
    logic [XLEN-1:0] id_pc;
    instr_u          id_word;

    alu_op_e         dec_op;
    logic [XLEN-1:0] dec_imm;
    logic            dec_use_imm;
    logic            dec_writes;
    logic            dec_branch;
    logic            dec_jal;
    logic [4:0]      dec_rd;
    logic [XLEN-1:0] rf_a, rf_b, opnd_a, opnd_b;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= if_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        id_pc   <= if_pc_i;
        id_word <= if_instr_i;
    end

    always_comb begin
        dec_op      = ALU_ADD;
        dec_imm     = '0;
        dec_use_imm = 1'b0;
        dec_writes  = 1'b0;
        dec_branch  = 1'b0;
        dec_jal     = 1'b0;
        case (id_word.r.opcode)
            OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_imm     = XLEN'($signed(id_word.i.imm12));
                dec_writes  = 1'b1;
                case (id_word.i.funct3)
                    F3_ADD_SUB: dec_op = ALU_ADD;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    default:    dec_writes = 1'b0;   // slt, shifts not kept
                endcase
            end
            OPC_OP: begin
                dec_writes = 1'b1;
                case (id_word.r.funct3)
                    F3_ADD_SUB: dec_op = id_word.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    default:    dec_writes = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_op      = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_imm     = XLEN'($signed({id_word.i.imm12, id_word.i.rs1,
                                             id_word.i.funct3, 12'b0}));
                dec_writes  = 1'b1;
            end
            OPC_BRANCH: begin
                dec_branch = (id_word.bj.funct3 == F3_BEQ) || (id_word.bj.funct3 == F3_BNE);
                dec_imm    = XLEN'($signed({id_word.bj.hi[6], id_word.bj.lo[0],
                                            id_word.bj.hi[5:0], id_word.bj.lo[4:1], 1'b0}));
            end
            OPC_JAL: begin
                dec_op     = ALU_LINK;
                dec_jal    = 1'b1;
                dec_writes = 1'b1;
                dec_imm    = XLEN'($signed({id_word.bj.hi[6], id_word.bj.rs1,
                                            id_word.bj.funct3, id_word.bj.rs2[0],
                                            id_word.bj.hi[5:0], id_word.bj.rs2[4:1], 1'b0}));
            end
            default: ;
        endcase
    end

    assign dec_rd = dec_writes ? id_word.r.rd : 5'd0;   // rd 0 means no write

    reg_file #(.XLEN(XLEN)) u_rf (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (id_word.r.rs1),
        .rs2_i      (id_word.r.rs2),
        .rs1_data_o (rf_a),
        .rs2_data_o (rf_b),
        .we_i       (wb_valid_i),
        .rd_i       (wb_rd_i),
        .rd_data_i  (wb_data_i)
    );

    // newest producer wins: execute, then writeback, then the file
    function automatic logic [XLEN-1:0] fwd_sel(input logic [4:0] rs,
                                               input logic [XLEN-1:0] rf_val);
        if (rs != 5'd0 && ex_fwd_valid_i && ex_rd_fwd_i == rs) begin
            return ex_result_i;
        end else if (rs != 5'd0 && wb_valid_i && wb_rd_i == rs) begin
            return wb_data_i;
        end
        return rf_val;
    endfunction

    always_comb begin
        opnd_a = fwd_sel(id_word.r.rs1, rf_a);
        opnd_b = fwd_sel(id_word.r.rs2, rf_b);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o        <= id_pc;
        ex_op_o        <= dec_op;
        ex_a_o         <= opnd_a;
        ex_b_o         <= dec_use_imm ? dec_imm : opnd_b;
        ex_imm_o       <= dec_imm;
        ex_rd_o        <= dec_rd;
        ex_is_branch_o <= dec_branch;
        ex_branch_ne_o <= (id_word.bj.funct3 == F3_BNE);
        ex_is_jal_o    <= dec_jal;
        ex_instr_o     <= id_word;
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_i,
    input  logic [4:0]      rs2_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            we_i,
    input  logic [4:0]      rd_i,
    input  logic [XLEN-1:0] rd_data_i
);

    logic [XLEN-1:0] regs [31:1];   // no storage behind x0

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (we_i) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

    // decode maps rd x0 to no-write, execute keeps that through writeback
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        we_i |-> rd_i != 5'd0
    );

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int XLEN       = 32,
    parameter int IMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          run_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr_i,
    input  logic [31:0]                   imem_wdata_i,
    input  logic                          redirect_i,
    input  logic [XLEN-1:0]               redirect_pc_i,
    output logic                          if_valid_o,
    output logic [XLEN-1:0]               if_pc_o,
    output logic [31:0]                   if_instr_o
);

    localparam int AW = $clog2(IMEM_WORDS);

    logic [31:0]     imem [IMEM_WORDS];
    logic [XLEN-1:0] pc;

    // load port, usable any time
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc <= '0;
        end else if (!run_i) begin
            pc <= '0;                  // parked until run
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else begin
            pc <= pc + XLEN'(4);
        end
    end

    assign if_valid_o = run_i;
    assign if_pc_o    = pc;
    assign if_instr_o = imem[pc[AW+1:2]];   // word index, upper bits wrap

    // targets come from execute, so alignment depends on the immediates there
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc[1:0] == 2'b00
    );

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    // major opcodes of the kept subset
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,    // lui
        ALU_LINK       // pc + 4
    } alu_op_e;

    // one instruction word, three ways of slicing it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] hi;      // imm bits scattered over the top
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] lo;
            logic [6:0] opcode;
        } bj;
    } instr_u;

endpackage
